/* fp_sqrt.f */
hdl/fp_sqrt_pkg.sv
hdl/sqrt_if.sv
hdl/int_sqrt_unit.sv
hdl/fp_sqrt_unit.sv
hdl/wb_sqrt_regs.sv
hdl/fp_sqrt_top.sv
test/tb_fp_sqrt.sv

/* hdl/fp_sqrt_pkg.sv */
// Shared widths, flag and class types and register map of the FP square-root peripheral
package fp_sqrt_pkg;

    // IEEE single-precision field widths
    localparam int exp_width   = 8;
    localparam int frac_width  = 23;
    localparam int float_width = 32;

    // Root bits including the hidden bit
    localparam int root_width = 24;

    // Width of the bit counter that runs from 0 to root_width
    localparam int cnt_width = $clog2(root_width + 1);

    localparam logic [float_width-1:0] canonical_nan = 32'h7fc0_0000;

    // RISC-V exception flags with nv in the top bit
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef enum logic [1:0] {
        class_sqrt = 2'd0,
        class_zero = 2'd1,
        class_inf  = 2'd2,
        class_nan  = 2'd3
    } result_class_e;

    // Word addresses of the bus register block
    typedef enum logic [1:0] {
        reg_src    = 2'd0,
        reg_ctrl   = 2'd1,
        reg_status = 2'd2,
        reg_result = 2'd3
    } wb_reg_e;

endpackage

/* hdl/fp_sqrt_top.sv */
// Square-root peripheral top level joining the Wishbone register block and the core
`timescale 1ns/1ps

module fp_sqrt_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);

    sqrt_if u_sif ();

    wb_sqrt_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .sif   (u_sif.bus)
    );

    fp_sqrt_unit u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .sif   (u_sif.core)
    );

endmodule

/* hdl/fp_sqrt_unit.sv */
// Single-precision square-root core that classifies, normalizes and packs the root
`timescale 1ns/1ps

module fp_sqrt_unit
    import fp_sqrt_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    sqrt_if.core   sif
);

    logic                    sign;
    logic [exp_width-1:0]    exp_f;
    logic [frac_width-1:0]   frac_f;
    result_class_e           cls;
    logic [exp_width:0]      exp_sum;
    logic [2*root_width-1:0] radicand;

    logic [root_width-1:0]   root;
    logic [root_width:0]     remnant;

    result_class_e           cls_q;
    logic [exp_width-1:0]    exp_q;

    always_comb begin
        sign   = sif.src[float_width-1];
        exp_f  = sif.src[float_width-2 -: exp_width];
        frac_f = sif.src[frac_width-1:0];

        // Subnormals fall into the zero class
        if ((exp_f == '1 && frac_f != '0) || sign) begin
            cls = class_nan;
        end else if (exp_f == '1) begin
            cls = class_inf;
        end else if (exp_f == '0) begin
            cls = class_zero;
        end else begin
            cls = class_sqrt;
        end
    end

    // Result exponent is (e + 127) / 2; an odd sum means the mantissa doubles
    always_comb begin
        exp_sum = {1'b0, exp_f} + (exp_width + 1)'((1 << (exp_width - 1)) - 1);
        if (exp_sum[0]) begin
            radicand = {1'b1, frac_f, {(root_width){1'b0}}};
        end else begin
            radicand = {2'b01, frac_f, {(root_width-1){1'b0}}};
        end
    end

    int_sqrt_unit u_root (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (sif.start),
        .flush    (sif.flush),
        .radicand (radicand),
        .root     (root),
        .remnant  (remnant),
        .busy     (sif.busy),
        .done     (sif.done)
    );

    // Class of the current or last operation, zero class out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cls_q <= class_zero;
        end else if (sif.start && !sif.busy && !sif.flush) begin
            cls_q <= cls;
        end
    end

    always_ff @(posedge clk) begin
        if (sif.start && !sif.busy && !sif.flush) begin
            exp_q <= exp_sum[exp_width:1];
        end
    end

    always_comb begin
        unique case (cls_q)
            class_sqrt: sif.result = {1'b0, exp_q, root[frac_width-1:0]};
            class_zero: sif.result = '0;
            class_inf:  sif.result = {1'b0, {(exp_width){1'b1}}, {(frac_width){1'b0}}};
            class_nan:  sif.result = canonical_nan;
            default:    sif.result = '0;
        endcase

        sif.flags.nv = (cls_q == class_nan);
        sif.flags.dz = 1'b0;
        sif.flags.of = 1'b0;
        sif.flags.uf = 1'b0;
        // Truncated root is inexact whenever a remainder is left
        sif.flags.nx = (cls_q == class_sqrt) && (remnant != '0);
    end

    a_class_known : assert property (@(posedge clk) disable iff (!rst_n)
        sif.done |-> !$isunknown(cls_q));

endmodule

/* hdl/int_sqrt_unit.sv */
// Restoring integer square root, one root bit per clock, with final remainder
`timescale 1ns/1ps

module int_sqrt_unit
    import fp_sqrt_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    flush,
    input  logic [2*root_width-1:0] radicand,
    output logic [root_width-1:0]   root,
    output logic [root_width:0]     remnant,
    output logic                    busy,
    output logic                    done
);

    logic [2*root_width-1:0] rad_q;
    logic [root_width-1:0]   root_q;
    logic [root_width:0]     rem_q;
    logic [cnt_width-1:0]    cnt_q;
    logic                    busy_q;
    logic                    done_q;

    logic [root_width+2:0] rem_shift;
    logic [root_width+2:0] trial;
    logic                  trial_neg;
    logic                  last_step;

    // Bring down the next two radicand bits and try to subtract 4*root+1
    always_comb begin
        rem_shift = {rem_q, rad_q[2*root_width-1 -: 2]};
        trial     = rem_shift - {1'b0, root_q, 2'b01};
        trial_neg = trial[root_width+2];
        last_step = (cnt_q == cnt_width'(root_width));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (flush) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (start && !busy_q) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (busy_q) begin
            if (last_step) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start && !busy_q && !flush) begin
            rad_q  <= radicand;
            root_q <= '0;
            rem_q  <= '0;
        end else if (busy_q && !last_step) begin
            rad_q <= {rad_q[2*root_width-3:0], 2'b00};
            if (trial_neg) begin
                // Root bit is zero and the remainder is restored
                rem_q  <= rem_shift[root_width:0];
                root_q <= {root_q[root_width-2:0], 1'b0};
            end else begin
                rem_q  <= trial[root_width:0];
                root_q <= {root_q[root_width-2:0], 1'b1};
            end
        end
    end

    assign root    = root_q;
    assign remnant = rem_q;
    assign busy    = busy_q;
    assign done    = done_q;

    a_busy_done_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(busy_q && done_q));

    // A start during an operation must not restart the bit count
    a_start_while_busy : assert property (@(posedge clk) disable iff (!rst_n)
        (start && busy_q && !flush && !last_step) |=> (cnt_q == $past(cnt_q) + 1'b1));

endmodule

/* hdl/sqrt_if.sv */
// Command and result channel between the bus register block and the square-root core
`timescale 1ns/1ps

interface sqrt_if
    import fp_sqrt_pkg::*;
();

    // Driven by the register block
    logic                   start;
    logic                   flush;
    logic [float_width-1:0] src;

    // Driven by the core
    logic [float_width-1:0] result;
    fflags_t                flags;
    logic                   busy;
    logic                   done;

    modport bus (
        output start, flush, src,
        input  result, flags, busy, done
    );

    modport core (
        input  start, flush, src,
        output result, flags, busy, done
    );

endinterface

/* hdl/wb_sqrt_regs.sv */
// Wishbone classic slave holding operand, control, status and result registers
`timescale 1ns/1ps

module wb_sqrt_regs
    import fp_sqrt_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    sqrt_if.bus         sif
);

    wb_reg_e                reg_sel;
    logic                   access;
    logic                   wr_en;
    logic [31:0]            rd_data;
    logic [float_width-1:0] src_q;
    logic                   ack_q;
    logic [31:0]            dat_r_q;

    // Access is accepted in its first cycle and ack follows on the next edge
    always_comb begin
        reg_sel = wb_reg_e'(adr);
        access  = cyc && stb && !ack_q;
        wr_en   = access && we;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            dat_r_q <= '0;
        end else begin
            ack_q <= access;
            if (access) begin
                dat_r_q <= rd_data;
            end
        end
    end

    // Operand register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q <= '0;
        end else if (wr_en && reg_sel == reg_src) begin
            src_q <= dat_w;
        end
    end

    // Control writes become single-cycle start and flush pulses
    always_comb begin
        sif.start = wr_en && (reg_sel == reg_ctrl) && dat_w[0];
        sif.flush = wr_en && (reg_sel == reg_ctrl) && dat_w[1];
        sif.src   = src_q;
    end

    always_comb begin
        unique case (reg_sel)
            reg_src:    rd_data = src_q;
            reg_ctrl:   rd_data = '0;
            reg_status: rd_data = {25'd0, sif.flags, sif.done, sif.busy};
            reg_result: rd_data = sif.result;
            default:    rd_data = '0;
        endcase
    end

    assign ack   = ack_q;
    assign dat_r = dat_r_q;

    a_ack_after_req : assert property (@(posedge clk) disable iff (!rst_n)
        ack_q |-> $past(cyc && stb));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the square-root peripheral testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fp_sqrt -f fp_sqrt.f \
    && ./obj_dir/Vtb_fp_sqrt | tee /dev/stderr | grep -q "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* test/tb_fp_sqrt.sv */
// Testbench for the square-root peripheral, driving it through Wishbone register accesses
`timescale 1ns/1ps

module tb_fp_sqrt
    import fp_sqrt_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    // Operand, expected result and expected flags {nv, dz, of, uf, nx}
    typedef struct packed {
        logic [31:0] src;
        logic [31:0] res;
        logic [4:0]  flags;
    } vector_t;

    vector_t vectors [0:13] = '{
        '{32'h4080_0000, 32'h4000_0000, 5'b00000},
        '{32'h3f80_0000, 32'h3f80_0000, 5'b00000},
        '{32'h4110_0000, 32'h4040_0000, 5'b00000},
        '{32'h3e80_0000, 32'h3f00_0000, 5'b00000},
        '{32'h0080_0000, 32'h2000_0000, 5'b00000},
        '{32'h4000_0000, 32'h3fb5_04f3, 5'b00001},
        '{32'h4040_0000, 32'h3fdd_b3d7, 5'b00001},
        '{32'h0000_0000, 32'h0000_0000, 5'b00000},
        '{32'h0000_0001, 32'h0000_0000, 5'b00000},
        '{32'h7f80_0000, 32'h7f80_0000, 5'b00000},
        '{32'hbf80_0000, 32'h7fc0_0000, 5'b10000},
        '{32'h8000_0000, 32'h7fc0_0000, 5'b10000},
        '{32'h7fc0_0000, 32'h7fc0_0000, 5'b10000},
        '{32'h7f80_0001, 32'h7fc0_0000, 5'b10000}
    };

    integer      seed;
    logic [31:0] rd;
    logic [31:0] st;
    logic [31:0] op;
    logic [31:0] rnd;
    logic [7:0]  op_exp;
    real         x_val;
    real         r_val;
    real         r_next;

    fp_sqrt_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("ERR %0t %s expected %08h actual %08h", $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    // One bus cycle that returns 1 ns after the edge showing ack
    task automatic bus_cycle(input logic wr, input logic [1:0] addr, input logic [31:0] data,
                             output logic [31:0] rdata);
        int n;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = addr;
        dat_w = data;
        n     = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!ack && n < 20);
        if (!ack) begin
            $display("bus access to address %0d got no ack within 20 cycles", addr);
            abort_run();
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'd0, data);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int polls;
        polls = 0;
        do begin
            wb_read(reg_status, status);
            polls++;
        end while (!status[1] && polls < 100);
        if (!status[1]) begin
            $display("done did not rise within 100 status polls");
            abort_run();
        end
    endtask

    task automatic run_op(input logic [31:0] operand);
        wb_write(reg_src, operand);
        wb_write(reg_ctrl, 32'h1);
        wait_done();
    endtask

    // Value of a 24 or 25 bit mantissa scaled by a biased exponent
    function automatic real mant_value(input int e, input longint m);
        return real'(m) * (2.0 ** real'(e - 150));
    endfunction

    initial begin
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = 2'd0;
        dat_w = 32'd0;
        seed  = 23060;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        wb_read(reg_status, rd);
        check_value("status", 32'd0, rd);
        wb_read(reg_result, rd);
        check_value("result", 32'd0, rd);

        foreach (vectors[i]) begin
            run_op(vectors[i].src);
            wb_read(reg_result, rd);
            check_value("result", vectors[i].res, rd);
            wb_read(reg_status, rd);
            check_value("status", {25'd0, vectors[i].flags, 2'b10}, rd);
        end

        // Flush in the middle of an operation
        wb_write(reg_src, 32'h4000_0000);
        wb_write(reg_ctrl, 32'h1);
        wb_read(reg_status, rd);
        check_value("status.busy_done", 32'd1, {30'd0, rd[1:0]});
        wb_write(reg_ctrl, 32'h2);
        repeat (12) begin
            wb_read(reg_status, rd);
            check_value("status.busy_done", 32'd0, {30'd0, rd[1:0]});
        end
        run_op(32'h4000_0000);
        wb_read(reg_result, rd);
        check_value("result", 32'h3fb5_04f3, rd);

        // Second start while busy must not disturb the running operation
        wb_write(reg_src, 32'h4080_0000);
        wb_write(reg_ctrl, 32'h1);
        wb_write(reg_src, 32'h4110_0000);
        wb_write(reg_ctrl, 32'h1);
        wb_read(reg_status, rd);
        check_value("status.busy_done", 32'd1, {30'd0, rd[1:0]});
        wait_done();
        wb_read(reg_result, rd);
        check_value("result", 32'h4000_0000, rd);
        wb_read(reg_src, rd);
        check_value("src", 32'h4110_0000, rd);

        // Random positive normals against the truncation bound
        repeat (20) begin
            rnd    = $random(seed);
            op_exp = 8'(rnd[30:23] % 8'd254) + 8'd1;
            op     = {1'b0, op_exp, rnd[22:0]};
            run_op(op);
            wb_read(reg_result, rd);
            wb_read(reg_status, st);
            x_val  = mant_value(int'(op[30:23]), longint'({1'b1, op[22:0]}));
            r_val  = mant_value(int'(rd[30:23]), longint'({1'b1, rd[22:0]}));
            r_next = mant_value(int'(rd[30:23]), longint'({1'b1, rd[22:0]}) + 64'd1);
            assert (rd[31] == 1'b0 && r_val * r_val <= x_val) else begin
                $display("root %08h of operand %08h squares above the operand", rd, op);
                abort_run();
            end
            assert (r_next * r_next > x_val) else begin
                $display("root %08h of operand %08h is below the truncated root", rd, op);
                abort_run();
            end
            check_value("status", {25'd0, 4'b0000, r_val * r_val != x_val, 2'b10}, st);
        end

        $display("all tests passed");
        $finish;
    end

endmodule
